/* sim.f */
src/sched_pkg.sv
src/ctrl_decoder.sv
src/slot_keeper.sv
src/desc_allocator.sv
src/scheduler_top.sv
verification/tb_clock.sv
verification/scheduler_tb.sv

/* Makefile */
# Verilator build and run of the scheduler testbench

VERILATOR ?= verilator
TOP       ?= scheduler_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation finished: PASS

.PHONY: sim clean

# The run passes only when the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* verification/scheduler_tb.sv */
`timescale 1ns/1ns

module scheduler_tb;

  import sched_pkg::*;

  localparam int CORE_COUNT      = 4;
  localparam int SLOT_COUNT      = 8;
  localparam int INTERFACE_COUNT = 2;
  localparam int HASH_SEL_OFFSET = 0;
  localparam int TIMEOUT         = 200;
  localparam int STREAM_MAX      = 8;

  logic                         clk;
  logic                         rst_r;
  logic                         ctrl_valid;
  ctrl_msg_t                    ctrl_msg;
  logic [INTERFACE_COUNT-1:0]   req_valid;
  hash_t [INTERFACE_COUNT-1:0]  req_hash;
  logic [INTERFACE_COUNT-1:0]   req_taken;
  logic [CORE_COUNT-1:0]        income_cores;
  core_id_t                     stat_read_core;
  logic                         desc_valid;
  desc_t                        desc;
  if_id_t                       desc_port;
  slot_t                        slot_count;
  logic                         slot_err;

  // Reference model of the pools and the output pipelines
  slot_t     pool [CORE_COUNT][$];
  int        taken_cnt [INTERFACE_COUNT];
  int        last_slot [INTERFACE_COUNT];
  logic      pend_valid;
  ctrl_msg_t pend_msg;
  int        count_d2 [CORE_COUNT];
  int        count_d3 [CORE_COUNT];
  core_id_t  sel_d1;
  core_id_t  sel_d2;
  logic      err_d1;
  logic      err_d2;
  logic      fair_on;
  int        prev_port;
  hash_t     stream_hash [INTERFACE_COUNT][STREAM_MAX];
  int        errors = 0;
  int        checks = 0;

  tb_clock clock_gen (
    .clk  (clk),
    .rst_r(rst_r)
  );

  scheduler_top dut (
    .clk           (clk),
    .rst_r         (rst_r),
    .ctrl_valid    (ctrl_valid),
    .ctrl_msg      (ctrl_msg),
    .req_valid     (req_valid),
    .req_hash      (req_hash),
    .req_taken     (req_taken),
    .income_cores  (income_cores),
    .stat_read_core(stat_read_core),
    .desc_valid    (desc_valid),
    .desc          (desc),
    .desc_port     (desc_port),
    .slot_count    (slot_count),
    .slot_err      (slot_err)
  );

  task automatic compare_value(input string name, input int got, input int exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("** Error at %0t ns: %s expected %0d, got %0d", $time, name, exp, got);
    end
  endtask

  task automatic report_failure(input string text);
    errors++;
    $display("Failure at %0t ns: %s", $time, text);
  endtask

  function automatic int core_of(input hash_t h);
    return int'(h[HASH_SEL_OFFSET +: CORE_ID_WIDTH]);
  endfunction

  function automatic hash_t hash_for(input core_id_t core);
    hash_t h;
    h = $urandom();
    h[HASH_SEL_OFFSET +: CORE_ID_WIDTH] = core;
    return h;
  endfunction

  // Checker, sampling on the rising edge before the DUT registers update
  always @(posedge clk) begin
    int       sizes [CORE_COUNT];
    int       exp_core;
    int       other;
    int       exp_slot;
    logic     disc;
    if (rst_r) begin
      for (int c = 0; c < CORE_COUNT; c++) begin
        pool[c].delete();
        count_d2[c] = 0;
        count_d3[c] = 0;
      end
      pend_valid = 1'b0;
      sel_d1     = '0;
      sel_d2     = '0;
      err_d1     = 1'b0;
      err_d2     = 1'b0;
      prev_port  = -1;
    end else begin
      disc = 1'b0;
      for (int c = 0; c < CORE_COUNT; c++) begin
        sizes[c] = pool[c].size();
      end
      compare_value("slot_count", slot_count, count_d3[sel_d2]);
      compare_value("slot_err", slot_err, err_d2);
      if (desc_valid) begin
        exp_core = core_of(req_hash[desc_port]);
        other    = 1 - int'(desc_port);
        compare_value("req_valid[desc_port]", req_valid[desc_port], 1);
        compare_value("req_taken", req_taken, 1 << desc_port);
        compare_value("desc.core", desc.core, exp_core);
        assert (pool[exp_core].size() != 0) else
          report_failure("descriptor issued for a core whose pool is empty");
        if (pool[exp_core].size() != 0) begin
          exp_slot = pool[exp_core].pop_front();
          compare_value("desc.slot", desc.slot, exp_slot);
        end
        assert (!(fair_on && prev_port == int'(desc_port) && req_valid[other])) else
          report_failure("an interface got two descriptors in a row while the other waited");
        prev_port = int'(desc_port);
        last_slot[desc_port] = desc.slot;
        taken_cnt[desc_port]++;
      end else begin
        compare_value("req_taken", req_taken, 0);
      end
      // Messages reach the keepers one edge after the decoder registers them
      if (pend_valid && pend_msg.msg_type == MSG_SLOT_INIT) begin
        pool[pend_msg.core].delete();
        for (int k = 1; k <= int'(pend_msg.slot) && k <= SLOT_COUNT; k++) begin
          pool[pend_msg.core].push_back(slot_t'(k));
        end
      end else if (pend_valid && pend_msg.msg_type == MSG_SLOT_RETURN) begin
        if (sizes[pend_msg.core] == SLOT_COUNT) begin
          disc = 1'b1;
        end else begin
          pool[pend_msg.core].push_back(pend_msg.slot);
        end
      end
      pend_valid = ctrl_valid;
      pend_msg   = ctrl_msg;
      err_d2     = err_d1;
      err_d1     = disc;
      count_d3   = count_d2;
      count_d2   = sizes;
      sel_d2     = sel_d1;
      sel_d1     = stat_read_core;
    end
  end

  task automatic send_ctrl(input ctrl_msg_type_e kind, input core_id_t core, input slot_t value);
    ctrl_msg.msg_type = kind;
    ctrl_msg.core     = core;
    ctrl_msg.slot     = value;
    ctrl_valid        = 1'b1;
    @(negedge clk);
    ctrl_valid = 1'b0;
  endtask

  task automatic expect_count(input core_id_t core, input int exp);
    stat_read_core = core;
    repeat (2) @(negedge clk);
    compare_value("slot_count", slot_count, exp);
  endtask

  task automatic raise_request(input int port, input hash_t hash);
    req_hash[port]  = hash;
    req_valid[port] = 1'b1;
  endtask

  task automatic wait_taken(input int port, input int start);
    int waited;
    waited = 0;
    while (taken_cnt[port] == start && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    req_valid[port] = 1'b0;
    if (taken_cnt[port] == start) begin
      report_failure($sformatf("request on interface %0d not taken in %0d cycles", port, TIMEOUT));
    end
  endtask

  task automatic issue_request(input int port, input hash_t hash);
    int start;
    start = taken_cnt[port];
    raise_request(port, hash);
    wait_taken(port, start);
  endtask

  task automatic run_stream(input int port, input int len);
    for (int n = 0; n < len; n++) begin
      issue_request(port, stream_hash[port][n]);
    end
  endtask

  initial begin
    int    waited;
    int    start;
    int    routed [CORE_COUNT];
    int    port_start [INTERFACE_COUNT];
    hash_t h;

    void'($urandom(32'h103e));
    ctrl_valid     = 1'b0;
    ctrl_msg       = '0;
    req_valid      = '0;
    req_hash       = '0;
    income_cores   = '1;
    stat_read_core = '0;
    fair_on        = 1'b0;
    waited         = 0;
    while (rst_r !== 1'b0 && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (rst_r !== 1'b0) begin
      report_failure("reset was never released");
    end

    // Idle after reset
    for (int c = 0; c < CORE_COUNT; c++) begin
      expect_count(core_id_t'(c), 0);
    end
    repeat (8) @(negedge clk);

    // Init one core and drain it in order
    stat_read_core = 2'd2;
    repeat (2) @(negedge clk);
    send_ctrl(MSG_SLOT_INIT, 2'd2, 4'd3);
    repeat (3) @(negedge clk);
    compare_value("slot_count", slot_count, 3);
    for (int k = 1; k <= 3; k++) begin
      issue_request(k % 2, hash_for(2'd2));
      compare_value("desc.slot", last_slot[k % 2], k);
    end
    expect_count(2'd2, 0);

    // Empty pool waits for a return
    send_ctrl(MSG_SLOT_INIT, 2'd1, 4'd0);
    start = taken_cnt[0];
    raise_request(0, hash_for(2'd1));
    repeat (12) @(negedge clk);
    compare_value("req_taken[0] pulses", taken_cnt[0], start);
    send_ctrl(MSG_SLOT_RETURN, 2'd1, 4'd5);
    wait_taken(0, start);
    compare_value("desc.slot", last_slot[0], 5);

    // Core masked out of income_cores waits for its bit
    send_ctrl(MSG_SLOT_INIT, 2'd3, 4'd2);
    income_cores[3] = 1'b0;
    start = taken_cnt[1];
    raise_request(1, hash_for(2'd3));
    repeat (12) @(negedge clk);
    compare_value("req_taken[1] pulses", taken_cnt[1], start);
    income_cores[3] = 1'b1;
    wait_taken(1, start);
    compare_value("desc.slot", last_slot[1], 1);

    // Random hashes over both interfaces, no core asked for more than it holds
    for (int c = 0; c < CORE_COUNT; c++) begin
      send_ctrl(MSG_SLOT_INIT, core_id_t'(c), slot_t'(SLOT_COUNT));
      routed[c] = 0;
    end
    repeat (2) @(negedge clk);
    for (int p = 0; p < INTERFACE_COUNT; p++) begin
      for (int n = 0; n < STREAM_MAX; n++) begin
        h = $urandom();
        while (routed[core_of(h)] >= SLOT_COUNT) begin
          h = $urandom();
        end
        routed[core_of(h)]++;
        stream_hash[p][n] = h;
      end
      port_start[p] = taken_cnt[p];
    end
    fork
      run_stream(0, STREAM_MAX);
      run_stream(1, STREAM_MAX);
    join
    repeat (4) @(negedge clk);
    for (int p = 0; p < INTERFACE_COUNT; p++) begin
      compare_value("req_taken pulses", taken_cnt[p] - port_start[p], STREAM_MAX);
    end

    // Return into a full pool; init length 15 clamps to the pool size
    stat_read_core = 2'd0;
    send_ctrl(MSG_SLOT_INIT, 2'd0, 4'd15);
    repeat (2) @(negedge clk);
    send_ctrl(MSG_SLOT_RETURN, 2'd0, 4'd9);
    repeat (2) @(negedge clk);
    compare_value("slot_err", slot_err, 1);
    @(negedge clk);
    compare_value("slot_count", slot_count, SLOT_COUNT);

    // Both interfaces hammer one core
    send_ctrl(MSG_SLOT_INIT, 2'd2, slot_t'(SLOT_COUNT));
    repeat (2) @(negedge clk);
    for (int p = 0; p < INTERFACE_COUNT; p++) begin
      for (int n = 0; n < SLOT_COUNT / 2; n++) begin
        stream_hash[p][n] = hash_for(2'd2);
      end
    end
    prev_port = -1;
    fair_on   = 1'b1;
    fork
      run_stream(0, SLOT_COUNT / 2);
      run_stream(1, SLOT_COUNT / 2);
    join
    fair_on = 1'b0;
    expect_count(2'd2, 0);

    repeat (5) @(negedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* verification/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
  output logic clk,
  output logic rst_r
);

  localparam int HALF_PERIOD  = 2;
  localparam int RESET_CYCLES = 3;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Reset drops on a falling edge, like the rest of the stimulus
  initial begin
    rst_r = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_r = 1'b0;
  end

endmodule

/* src/scheduler_top.sv */
`timescale 1ns/1ns

module scheduler_top #(
  parameter int CORE_COUNT      = 4,
  parameter int SLOT_COUNT      = 8,
  parameter int INTERFACE_COUNT = 2,
  parameter int HASH_SEL_OFFSET = 0
) (
  input  logic                                  clk,
  input  logic                                  rst_r,
  input  logic                                  ctrl_valid,
  input  sched_pkg::ctrl_msg_t                  ctrl_msg,
  input  logic [INTERFACE_COUNT-1:0]            req_valid,
  input  sched_pkg::hash_t [INTERFACE_COUNT-1:0] req_hash,
  output logic [INTERFACE_COUNT-1:0]            req_taken,
  input  logic [CORE_COUNT-1:0]                 income_cores,
  input  sched_pkg::core_id_t                   stat_read_core,
  output logic                                  desc_valid,
  output sched_pkg::desc_t                      desc,
  output sched_pkg::if_id_t                     desc_port,
  output sched_pkg::slot_t                      slot_count,
  output logic                                  slot_err
);

  import sched_pkg::*;

  logic [CORE_COUNT-1:0]  init_valid;
  logic [CORE_COUNT-1:0]  ret_valid;
  slot_t                  slot_value;
  slot_t [CORE_COUNT-1:0] head;
  logic [CORE_COUNT-1:0]  head_valid;
  slot_t [CORE_COUNT-1:0] keeper_count;
  logic [CORE_COUNT-1:0]  enq_err;
  logic [CORE_COUNT-1:0]  pop;

  // Status readback pipeline
  slot_t [CORE_COUNT-1:0] count_r;
  core_id_t               stat_read_core_r;

  ctrl_decoder #(
    .CORE_COUNT(CORE_COUNT)
  ) decoder_inst (
    .clk       (clk),
    .rst_r     (rst_r),
    .ctrl_valid(ctrl_valid),
    .ctrl_msg  (ctrl_msg),
    .init_valid(init_valid),
    .ret_valid (ret_valid),
    .slot_value(slot_value)
  );

  for (genvar c = 0; c < CORE_COUNT; c++) begin : g_keeper
    slot_keeper #(
      .SLOT_COUNT(SLOT_COUNT)
    ) keeper_inst (
      .clk       (clk),
      .rst_r     (rst_r),
      .init_valid(init_valid[c]),
      .ret_valid (ret_valid[c]),
      .slot_value(slot_value),
      .pop       (pop[c]),
      .head      (head[c]),
      .head_valid(head_valid[c]),
      .count     (keeper_count[c]),
      .enq_err   (enq_err[c])
    );
  end

  desc_allocator #(
    .CORE_COUNT     (CORE_COUNT),
    .INTERFACE_COUNT(INTERFACE_COUNT),
    .HASH_SEL_OFFSET(HASH_SEL_OFFSET)
  ) allocator_inst (
    .clk         (clk),
    .rst_r       (rst_r),
    .req_valid   (req_valid),
    .req_hash    (req_hash),
    .income_cores(income_cores),
    .head        (head),
    .head_valid  (head_valid),
    .req_taken   (req_taken),
    .pop         (pop),
    .desc_valid  (desc_valid),
    .desc        (desc),
    .desc_port   (desc_port)
  );

  always_ff @(posedge clk) begin
    if (rst_r) begin
      stat_read_core_r <= '0;
      count_r          <= '0;
      slot_count       <= '0;
      slot_err         <= 1'b0;
    end else begin
      stat_read_core_r <= stat_read_core;
      count_r          <= keeper_count;
      slot_count       <= (int'(stat_read_core_r) < CORE_COUNT) ?
                          count_r[stat_read_core_r] : '0;
      // Any keeper rejecting a return
      slot_err         <= |enq_err;
    end
  end

endmodule

/* src/desc_allocator.sv */
`timescale 1ns/1ns

module desc_allocator #(
  parameter int CORE_COUNT      = 4,
  parameter int INTERFACE_COUNT = 2,
  parameter int HASH_SEL_OFFSET = 0
) (
  input  logic                                  clk,
  input  logic                                  rst_r,
  input  logic [INTERFACE_COUNT-1:0]            req_valid,
  input  sched_pkg::hash_t [INTERFACE_COUNT-1:0] req_hash,
  input  logic [CORE_COUNT-1:0]                 income_cores,
  input  sched_pkg::slot_t [CORE_COUNT-1:0]     head,
  input  logic [CORE_COUNT-1:0]                 head_valid,
  output logic [INTERFACE_COUNT-1:0]            req_taken,
  output logic [CORE_COUNT-1:0]                 pop,
  output logic                                  desc_valid,
  output sched_pkg::desc_t                      desc,
  output sched_pkg::if_id_t                     desc_port
);

  import sched_pkg::*;

  // Arbiter state
  logic [INTERFACE_COUNT-1:0] desc_req;
  logic                       grant_v;
  logic [INTERFACE_COUNT-1:0] grant_onehot;
  if_id_t                     grant_port;
  if_id_t                     last_port;
  hash_t                      grant_hash;

  // Grant held for the availability check
  logic                       grant_v_r;
  logic [INTERFACE_COUNT-1:0] grant_mask_r;
  if_id_t                     grant_port_r;
  core_id_t                   dest_core_r;

  // Per-core stall: a core that ran dry is reserved for its first waiter
  logic [CORE_COUNT-1:0]      stall_v;
  if_id_t [CORE_COUNT-1:0]    stall_port;

  logic core_ok;
  logic core_avail;
  logic stalled;
  logic is_waiter;
  logic issue;

  // The interface granted last cycle is still being checked, so skip it
  assign desc_req = req_valid & ~grant_mask_r;

  // Round-robin search starting after the last grant
  always_comb begin
    int idx;
    grant_v      = 1'b0;
    grant_onehot = '0;
    grant_port   = last_port;
    for (int i = 1; i <= INTERFACE_COUNT; i++) begin
      idx = (int'(last_port) + i) % INTERFACE_COUNT;
      if (!grant_v && desc_req[idx]) begin
        grant_v           = 1'b1;
        grant_onehot[idx] = 1'b1;
        grant_port        = if_id_t'(idx);
      end
    end
  end

  assign grant_hash = req_hash[grant_port];

  always_ff @(posedge clk) begin
    if (rst_r) begin
      grant_v_r    <= 1'b0;
      grant_mask_r <= '0;
      grant_port_r <= '0;
      dest_core_r  <= '0;
      last_port    <= '0;
    end else begin
      grant_v_r    <= grant_v;
      grant_mask_r <= grant_onehot;
      grant_port_r <= grant_port;
      dest_core_r  <= grant_hash[HASH_SEL_OFFSET +: CORE_ID_WIDTH];
      if (grant_v) begin
        last_port <= grant_port;
      end
    end
  end

  // Second cycle: slot availability and stall check
  assign core_ok    = (int'(dest_core_r) < CORE_COUNT);
  assign core_avail = core_ok && head_valid[dest_core_r] && income_cores[dest_core_r];
  assign stalled    = core_ok && stall_v[dest_core_r];
  assign is_waiter  = (stall_port[dest_core_r] == grant_port_r);
  assign issue      = grant_v_r && core_avail && (!stalled || is_waiter);

  always_comb begin
    for (int c = 0; c < CORE_COUNT; c++) begin
      pop[c] = issue && (dest_core_r == c);
    end
  end

  assign req_taken  = issue ? grant_mask_r : '0;
  assign desc_valid = issue;
  assign desc.core  = dest_core_r;
  assign desc.slot  = core_ok ? head[dest_core_r] : '0;
  assign desc_port  = grant_port_r;

  always_ff @(posedge clk) begin
    if (rst_r) begin
      stall_v <= '0;
    end else if (grant_v_r && core_ok) begin
      if (!core_avail && !stall_v[dest_core_r]) begin
        stall_v[dest_core_r] <= 1'b1;
      end else if (issue && stall_v[dest_core_r]) begin
        // Waiter got its slot, release the core
        stall_v[dest_core_r] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (grant_v_r && core_ok && !core_avail && !stall_v[dest_core_r]) begin
      stall_port[dest_core_r] <= grant_port_r;
    end
  end

endmodule

/* src/slot_keeper.sv */
`timescale 1ns/1ns

module slot_keeper #(
  parameter int SLOT_COUNT = 8
) (
  input  logic             clk,
  input  logic             rst_r,
  input  logic             init_valid,
  input  logic             ret_valid,
  input  sched_pkg::slot_t slot_value,
  input  logic             pop,
  output sched_pkg::slot_t head,
  output logic             head_valid,
  output sched_pkg::slot_t count,
  output logic             enq_err
);

  import sched_pkg::*;

  localparam int PTR_WIDTH = (SLOT_COUNT > 1) ? $clog2(SLOT_COUNT) : 1;

  typedef logic [PTR_WIDTH-1:0] ptr_t;

  slot_t mem [SLOT_COUNT];
  ptr_t  rd_ptr;
  ptr_t  wr_ptr;
  slot_t init_len;
  logic  full;
  logic  do_pop;
  logic  do_ret;

  function automatic ptr_t ptr_next(input ptr_t p);
    if (p == ptr_t'(SLOT_COUNT - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  // Init length is clamped to the pool size
  assign init_len = (slot_value > slot_t'(SLOT_COUNT)) ? slot_t'(SLOT_COUNT) : slot_value;

  assign full       = (count == slot_t'(SLOT_COUNT));
  assign head_valid = (count != '0);
  assign head       = mem[rd_ptr];

  // Init takes priority over a return or pop in the same cycle
  assign do_pop = pop && head_valid && !init_valid;
  assign do_ret = ret_valid && !full && !init_valid;

  always_ff @(posedge clk) begin
    if (rst_r) begin
      rd_ptr  <= '0;
      wr_ptr  <= '0;
      count   <= '0;
      enq_err <= 1'b0;
    end else begin
      enq_err <= ret_valid && full && !init_valid;
      if (init_valid) begin
        rd_ptr <= '0;
        wr_ptr <= (init_len == slot_t'(SLOT_COUNT)) ? '0 : ptr_t'(init_len);
        count  <= init_len;
      end else begin
        if (do_pop) begin
          rd_ptr <= ptr_next(rd_ptr);
        end
        if (do_ret) begin
          wr_ptr <= ptr_next(wr_ptr);
        end
        case ({do_ret, do_pop})
          2'b10:   count <= count + 1'b1;
          2'b01:   count <= count - 1'b1;
          default: count <= count;
        endcase
      end
    end
  end

  // Pool contents
  always_ff @(posedge clk) begin
    if (init_valid) begin
      for (int i = 0; i < SLOT_COUNT; i++) begin
        mem[i] <= slot_t'(i + 1);
      end
    end else if (do_ret) begin
      mem[wr_ptr] <= slot_value;
    end
  end

endmodule

/* src/ctrl_decoder.sv */
`timescale 1ns/1ns

module ctrl_decoder #(
  parameter int CORE_COUNT = 4
) (
  input  logic                  clk,
  input  logic                  rst_r,
  input  logic                  ctrl_valid,
  input  sched_pkg::ctrl_msg_t  ctrl_msg,
  output logic [CORE_COUNT-1:0] init_valid,
  output logic [CORE_COUNT-1:0] ret_valid,
  output sched_pkg::slot_t      slot_value
);

  import sched_pkg::*;

  logic [CORE_COUNT-1:0] core_sel;
  logic                  is_init;
  logic                  is_ret;

  // One-hot select of the sending core, empty for cores beyond CORE_COUNT
  always_comb begin
    for (int c = 0; c < CORE_COUNT; c++) begin
      core_sel[c] = ctrl_valid && (ctrl_msg.core == c);
    end
  end

  assign is_init = (ctrl_msg.msg_type == MSG_SLOT_INIT);
  assign is_ret  = (ctrl_msg.msg_type == MSG_SLOT_RETURN);

  always_ff @(posedge clk) begin
    if (rst_r) begin
      init_valid <= '0;
      ret_valid  <= '0;
    end else begin
      init_valid <= is_init ? core_sel : '0;
      ret_valid  <= is_ret ? core_sel : '0;
    end
  end

  // Slot number or init length, shared by all keepers
  always_ff @(posedge clk) begin
    slot_value <= ctrl_msg.slot;
  end

endmodule

/* src/sched_pkg.sv */
package sched_pkg;

  // Widths of the scheduler's fields
  localparam int CORE_ID_WIDTH   = 2;
  localparam int SLOT_WIDTH      = 4;
  localparam int INTERFACE_WIDTH = 1;
  localparam int HASH_WIDTH      = 32;

  typedef logic [CORE_ID_WIDTH-1:0]   core_id_t;

  // Slot 0 is reserved, so a pool holds at most 15 slots
  typedef logic [SLOT_WIDTH-1:0]      slot_t;

  typedef logic [INTERFACE_WIDTH-1:0] if_id_t;
  typedef logic [HASH_WIDTH-1:0]      hash_t;

  // Control message kinds; other codes are ignored by the decoder
  typedef enum logic [3:0] {
    MSG_SLOT_RETURN = 4'd0,
    MSG_SLOT_INIT   = 4'd3
  } ctrl_msg_type_e;

  // For init the slot field carries the number of slots to load
  typedef struct packed {
    ctrl_msg_type_e msg_type;
    core_id_t       core;
    slot_t          slot;
  } ctrl_msg_t;

  typedef struct packed {
    core_id_t core;
    slot_t    slot;
  } desc_t;

endpackage
